// ==== verilog.f ====
logic/mipsPkg.sv
logic/pipeReg.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/pipeControl.sv
logic/executeUnit.sv
logic/dataMem.sv
logic/mipsCore.sv
verif/clkGen.sv
verif/mipsCore_properties.sv
verif/mipsCore_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mipsCore_tb \
    -f verilog.f -o mipsCoreSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/mipsCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

// ==== verif/mipsCore_tb.sv ====
// Testbench for the pipelined core: program table, expected events, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module mipsCore_tb;
    import mipsPkg::*;

    localparam int NUM_EVENTS   = 16;
    localparam int DRAIN_CYCLES = 10;
    localparam int CYCLE_LIMIT  = 8 * NUM_EVENTS + 20;

    typedef struct packed {
        logic        isStore;
        logic [4:0]  regNum;
        logic [31:0] addr;
        logic [31:0] pc;
        logic [31:0] value;
    } expEvent_t;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] instrAddr;
    logic        commitValid;
    logic [4:0]  commitReg;
    logic [31:0] commitData;
    logic [31:0] commitPc;
    logic        storeValid;
    logic [31:0] storeAddr;
    logic [31:0] storeData;

    logic [31:0] progMem [32];
    expEvent_t   expEvents [NUM_EVENTS];
    int          eventIdx;
    int          cycleCount;
    int          drainCount;

    clkGen clkGen_i (.clk, .rst);

    mipsCore dut_i (
        .clk, .rst, .instr, .instrAddr, .commitValid, .commitReg, .commitData,
        .commitPc, .storeValid, .storeAddr, .storeData
    );

    ////////////////////////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] rTypeWord(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd, input logic [5:0] funct);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jumpWord(input logic [31:0] target);
        return {OP_J, target[27:2]};
    endfunction

    // Row is the program table index of the committing instruction
    function automatic expEvent_t commitEvent(input logic [4:0] regNum,
                                              input logic [31:0] value, input int row);
        return '{isStore: 1'b0, regNum: regNum, addr: 32'h0, pc: 32'(row) * 32'd4,
                 value: value};
    endfunction

    function automatic expEvent_t storeEvent(input logic [31:0] addr, input logic [31:0] value);
        return '{isStore: 1'b1, regNum: 5'd0, addr: addr, pc: 32'h0, value: value};
    endfunction

    ////////////////////////////////////////////////////////////
    // Program and expected events
    ////////////////////////////////////////////////////////////
    // Row index is the word address; unused rows stay as a no-op
    task automatic loadProgram();
        for (int i = 0; i < 32; i++) begin
            progMem[i] = 32'h0;
        end
        progMem[0]  = iTypeWord(OP_ORI, 5'd0, 5'd1, 16'h1234);
        progMem[1]  = iTypeWord(OP_LUI, 5'd0, 5'd2, 16'hABCD);
        progMem[2]  = rTypeWord(5'd1, 5'd2, 5'd3, FN_ADDU);
        progMem[3]  = rTypeWord(5'd3, 5'd1, 5'd4, FN_SUBU);
        progMem[4]  = iTypeWord(OP_ORI, 5'd0, 5'd0, 16'h5555);    // r0 write, no commit
        progMem[5]  = rTypeWord(5'd4, 5'd3, 5'd5, FN_ADDU);
        progMem[6]  = iTypeWord(OP_ORI, 5'd0, 5'd6, 16'h0040);
        progMem[7]  = iTypeWord(OP_SW, 5'd6, 5'd5, 16'h0008);
        progMem[8]  = iTypeWord(OP_LW, 5'd6, 5'd7, 16'h0008);
        progMem[9]  = rTypeWord(5'd7, 5'd1, 5'd8, FN_ADDU);       // load-use
        progMem[10] = iTypeWord(OP_BEQ, 5'd8, 5'd5, 16'h0004);    // not taken, stalls on r8
        progMem[11] = iTypeWord(OP_ORI, 5'd0, 5'd9, 16'h0009);
        progMem[12] = iTypeWord(OP_ORI, 5'd0, 5'd10, 16'h000A);
        progMem[13] = iTypeWord(OP_BEQ, 5'd9, 5'd9, 16'h0003);    // taken to 0x44
        progMem[14] = iTypeWord(OP_ORI, 5'd0, 5'd11, 16'h0011);
        progMem[15] = iTypeWord(OP_ORI, 5'd0, 5'd12, 16'h0BAD);
        progMem[16] = iTypeWord(OP_ORI, 5'd0, 5'd13, 16'h0BAD);
        progMem[17] = iTypeWord(OP_LW, 5'd6, 5'd14, 16'h0008);
        progMem[18] = iTypeWord(OP_BEQ, 5'd14, 5'd7, 16'h0002);   // load then beq, taken
        progMem[19] = rTypeWord(5'd14, 5'd1, 5'd15, FN_SUBU);
        progMem[20] = iTypeWord(OP_ORI, 5'd0, 5'd16, 16'h0BAD);
        progMem[21] = jumpWord(32'h0000_0060);
        progMem[22] = iTypeWord(OP_ORI, 5'd0, 5'd17, 16'h0017);
        progMem[23] = iTypeWord(OP_ORI, 5'd0, 5'd18, 16'h0BAD);
        progMem[24] = iTypeWord(OP_SW, 5'd6, 5'd17, 16'h0000);
        progMem[25] = jumpWord(32'h0000_0064);                    // spins here
    endtask

    task automatic loadEvents();
        expEvents[0]  = commitEvent(5'd1, 32'h0000_1234, 0);
        expEvents[1]  = commitEvent(5'd2, 32'hABCD_0000, 1);
        expEvents[2]  = commitEvent(5'd3, 32'hABCD_1234, 2);
        expEvents[3]  = commitEvent(5'd4, 32'hABCD_0000, 3);
        expEvents[4]  = commitEvent(5'd5, 32'h579A_1234, 5);
        expEvents[5]  = commitEvent(5'd6, 32'h0000_0040, 6);
        expEvents[6]  = storeEvent(32'h0000_0048, 32'h579A_1234);
        expEvents[7]  = commitEvent(5'd7, 32'h579A_1234, 8);
        expEvents[8]  = commitEvent(5'd8, 32'h579A_2468, 9);
        expEvents[9]  = commitEvent(5'd9, 32'h0000_0009, 11);
        expEvents[10] = commitEvent(5'd10, 32'h0000_000A, 12);
        expEvents[11] = commitEvent(5'd11, 32'h0000_0011, 14);
        expEvents[12] = commitEvent(5'd14, 32'h579A_1234, 17);
        expEvents[13] = commitEvent(5'd15, 32'h579A_0000, 19);
        expEvents[14] = commitEvent(5'd17, 32'h0000_0017, 22);
        expEvents[15] = storeEvent(32'h0000_0040, 32'h0000_0017);
    endtask

    // Fetch port answers in the same cycle; past the table it reads a no-op
    always_comb begin
        if (instrAddr[31:7] == 25'd0) begin
            instr = progMem[instrAddr[6:2]];
        end else begin
            instr = 32'h0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////
    task automatic compareValue(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: event %0d %s got 0x%08h expected 0x%08h",
                     $time, eventIdx, what, actual, expected);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic checkEvent(input logic isStore, input logic [4:0] regNum,
                              input logic [31:0] addr, input logic [31:0] value,
                              input logic [31:0] pc);
        expEvent_t entry;
        if (eventIdx >= NUM_EVENTS) begin
            $display("Unexpected extra event at %0t after all %0d expected events",
                     $time, NUM_EVENTS);
            $display("sim failed");
            $fatal(1);
        end else begin
            entry = expEvents[eventIdx];
            compareValue(32'(isStore), 32'(entry.isStore), "event kind (1 = store)");
            if (isStore) begin
                compareValue(addr, entry.addr, "store address");
            end else begin
                compareValue(32'(regNum), 32'(entry.regNum), "commit register");
                compareValue(pc, entry.pc, "commit PC");
            end
            compareValue(value, entry.value, isStore ? "store data" : "commit data");
            eventIdx++;
        end
    endtask

    // Outputs sampled at the edge hold last cycle's settled values
    initial begin
        eventIdx   = 0;
        cycleCount = 0;
        drainCount = 0;
        loadProgram();
        loadEvents();
        wait (rst == 1'b0);
        while (eventIdx < NUM_EVENTS || drainCount < DRAIN_CYCLES) begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > CYCLE_LIMIT) begin
                $display("Timeout after %0d cycles with %0d of %0d events seen",
                         cycleCount, eventIdx, NUM_EVENTS);
                $display("sim failed");
                $fatal(1);
            end else begin
                // WB is older than MEM, so commit goes first
                if (commitValid) begin
                    checkEvent(1'b0, commitReg, 32'h0, commitData, commitPc);
                end
                if (storeValid) begin
                    checkEvent(1'b1, 5'd0, storeAddr, storeData, 32'h0);
                end
                if (eventIdx == NUM_EVENTS) begin
                    drainCount++;
                end
            end
        end
        if (eventIdx == NUM_EVENTS) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== verif/mipsCore_properties.sv ====
// Concurrent assertions on the core ports and stall signal, bound into the core
`timescale 1ns/1ps
`default_nettype none

module mipsCore_properties (
    input logic        clk,
    input logic        rst,
    input logic [31:0] instrAddr,
    input logic        commitValid,
    input logic [4:0]  commitReg,
    input logic [31:0] commitData,
    input logic [31:0] commitPc,
    input logic        storeValid,
    input logic        idExClear
);

    // Load data from an unwritten word would show up here
    commitKnown: assert property (@(posedge clk) disable iff (rst)
        commitValid |-> !$isunknown({commitReg, commitData, commitPc}))
        else $error("Commit with unknown register, data or PC");

    fetchAligned: assert property (@(posedge clk) disable iff (rst)
        instrAddr[1:0] == 2'b00)
        else $error("Fetch address not word aligned");

    // Every stage register clears to a bubble
    quietAfterReset: assert property (@(posedge clk)
        rst |=> !commitValid && !storeValid)
        else $error("Commit or store valid right after reset");

    // Worst case is a load feeding beq
    stallBounded: assert property (@(posedge clk) disable iff (rst)
        idExClear && $past(idExClear) |-> !$past(idExClear, 2))
        else $error("Stall longer than two cycles");

endmodule

bind mipsCore mipsCore_properties props_i (
    .clk, .rst, .instrAddr, .commitValid, .commitReg, .commitData, .commitPc,
    .storeValid, .idExClear
);

`default_nettype wire

// ==== verif/clkGen.sv ====
// Testbench clock and power-on reset
`timescale 1ns/1ps
`default_nettype none

module clkGen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== logic/mipsCore.sv ====
// Five-stage MIPS core top level: stages, stage registers, control and visible ports
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    output logic [31:0] instrAddr,
    output logic        commitValid,
    output logic [4:0]  commitReg,
    output logic [31:0] commitData,
    output logic [31:0] commitPc,
    output logic        storeValid,
    output logic [31:0] storeAddr,
    output logic [31:0] storeData
);
    import mipsPkg::*;

    ifId_t       fetchStage;
    ifId_t       decodeStage;
    idEx_t       decodeNext;
    idEx_t       executeStage;
    exMem_t      memoryNext;
    exMem_t      memoryStage;
    memWb_t      writebackNext;
    memWb_t      writebackStage;
    ctrlWord_t   decodeCtrl;
    fwdSel_t     fwdA;
    fwdSel_t     fwdB;
    logic [31:0] rfDataA;
    logic [31:0] rfDataB;
    logic [31:0] operandA;
    logic [31:0] operandB;
    logic [31:0] dmemReadData;
    logic        pcEnable;
    logic        ifIdEnable;
    logic        idExClear;
    logic        branchTaken;
    logic        jump;

    ////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////
    fetchUnit fetch_i (
        .clk, .rst, .pcEnable, .branchTaken, .jump,
        .decodeStage, .instr, .instrAddr, .fetchStage
    );

    pipeReg #(.payload_t(ifId_t)) ifIdReg_i (
        .clk, .rst, .enable(ifIdEnable), .clear(1'b0), .d(fetchStage), .q(decodeStage)
    );

    regFile regs_i (
        .clk, .rst,
        .writeEnable (writebackStage.ctrl.regWrite),
        .writeReg    (writebackStage.ctrl.destReg),
        .readRegA    (decodeStage.instr[RS_HI:RS_LO]),
        .readRegB    (decodeStage.instr[RT_HI:RT_LO]),
        .writeData   (writebackStage.writeValue),
        .readDataA   (rfDataA),
        .readDataB   (rfDataB)
    );

    pipeControl control_i (
        .decodeStage, .executeStage, .memoryStage, .writebackStage,
        .rfDataA, .rfDataB, .decodeCtrl, .operandA, .operandB,
        .pcEnable, .ifIdEnable, .idExClear, .branchTaken, .jump, .fwdA, .fwdB
    );

    assign decodeNext = '{
        ctrl:    decodeCtrl,
        pc:      decodeStage.pc,
        rsNum:   decodeStage.instr[RS_HI:RS_LO],
        rtNum:   decodeStage.instr[RT_HI:RT_LO],
        rsValue: operandA,
        rtValue: operandB,
        immWord: {16'h0000, decodeStage.instr[IMM_HI:IMM_LO]}
    };

    pipeReg #(.payload_t(idEx_t)) idExReg_i (
        .clk, .rst, .enable(1'b1), .clear(idExClear), .d(decodeNext), .q(executeStage)
    );

    ////////////////////////////////////////////////////////////
    // Execute, memory, writeback
    ////////////////////////////////////////////////////////////
    executeUnit execute_i (
        .executeStage, .memResult(memoryStage.aluResult),
        .wbResult(writebackStage.writeValue), .fwdA, .fwdB, .memoryNext
    );

    pipeReg #(.payload_t(exMem_t)) exMemReg_i (
        .clk, .rst, .enable(1'b1), .clear(1'b0), .d(memoryNext), .q(memoryStage)
    );

    dataMem dmem_i (
        .clk,
        .writeEnable (memoryStage.ctrl.memWrite),
        .addr        (memoryStage.aluResult),
        .writeData   (memoryStage.storeData),
        .readData    (dmemReadData)
    );

    assign writebackNext.ctrl       = memoryStage.ctrl;
    assign writebackNext.pc         = memoryStage.pc;
    assign writebackNext.writeValue = memoryStage.ctrl.memRead ? dmemReadData
                                                               : memoryStage.aluResult;

    pipeReg #(.payload_t(memWb_t)) memWbReg_i (
        .clk, .rst, .enable(1'b1), .clear(1'b0), .d(writebackNext), .q(writebackStage)
    );

    // Architectural events
    assign commitValid = writebackStage.ctrl.regWrite && writebackStage.ctrl.destReg != 5'd0;
    assign commitReg   = writebackStage.ctrl.destReg;
    assign commitData  = writebackStage.writeValue;
    assign commitPc    = writebackStage.pc;
    assign storeValid  = memoryStage.ctrl.memWrite;
    assign storeAddr   = memoryStage.aluResult;
    assign storeData   = memoryStage.storeData;

endmodule

`default_nettype wire

// ==== logic/dataMem.sv ====
// Word-addressed data memory, synchronous write and combinational read
`timescale 1ns/1ps
`default_nettype none

module dataMem (
    input  logic        clk,
    input  logic        writeEnable,
    input  logic [31:0] addr,
    input  logic [31:0] writeData,
    output logic [31:0] readData
);
    import mipsPkg::*;

    localparam int INDEX_BITS = $clog2(DMEM_WORDS);

    logic [31:0]           mem [DMEM_WORDS];
    logic [INDEX_BITS-1:0] index;

    // Byte address to word index
    assign index = addr[INDEX_BITS+1:2];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[index] <= writeData;
        end
    end

    assign readData = mem[index];

endmodule

`default_nettype wire

// ==== logic/executeUnit.sv ====
// Execute stage: operand forwarding, immediate extension and ALU
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  mipsPkg::idEx_t  executeStage,
    input  logic [31:0]     memResult,
    input  logic [31:0]     wbResult,
    input  mipsPkg::fwdSel_t fwdA,
    input  mipsPkg::fwdSel_t fwdB,
    output mipsPkg::exMem_t memoryNext
);
    import mipsPkg::*;

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] immExt;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [15:0] imm;

    assign srcA = (fwdA == FWD_MEM) ? memResult :
                  (fwdA == FWD_WB)  ? wbResult  : executeStage.rsValue;
    assign srcB = (fwdB == FWD_MEM) ? memResult :
                  (fwdB == FWD_WB)  ? wbResult  : executeStage.rtValue;

    // Zero extension for ori and lui, sign extension otherwise
    assign imm    = executeStage.immWord[15:0];
    assign immExt = executeStage.ctrl.zeroExtend ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    assign aluB   = executeStage.ctrl.aluSrcImm ? immExt : srcB;

    always_comb begin
        case (executeStage.ctrl.aluOp)
            ALU_SUB: aluResult = srcA - aluB;
            ALU_OR:  aluResult = srcA | aluB;
            ALU_LUI: aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = srcA + aluB;
        endcase
    end

    assign memoryNext.ctrl      = executeStage.ctrl;
    assign memoryNext.pc        = executeStage.pc;
    assign memoryNext.aluResult = aluResult;
    // Store data is the forwarded rt
    assign memoryNext.storeData = srcB;

endmodule

`default_nettype wire

// ==== logic/pipeControl.sv ====
// Decoder, hazard detection, stall generation and forwarding for decode and execute
`timescale 1ns/1ps
`default_nettype none

module pipeControl (
    input  mipsPkg::ifId_t     decodeStage,
    input  mipsPkg::idEx_t     executeStage,
    input  mipsPkg::exMem_t    memoryStage,
    input  mipsPkg::memWb_t    writebackStage,
    input  logic [31:0]        rfDataA,
    input  logic [31:0]        rfDataB,
    output mipsPkg::ctrlWord_t decodeCtrl,
    output logic [31:0]        operandA,
    output logic [31:0]        operandB,
    output logic               pcEnable,
    output logic               ifIdEnable,
    output logic               idExClear,
    output logic               branchTaken,
    output logic               jump,
    output mipsPkg::fwdSel_t   fwdA,
    output mipsPkg::fwdSel_t   fwdB
);
    import mipsPkg::*;

    logic [5:0] op;
    logic [5:0] funct;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic       usesRs;
    logic       usesRt;
    logic       isBeq;
    logic       memFwdOk;
    logic       wbFwdOk;
    logic       stall;

    assign op    = decodeStage.instr[OP_HI:OP_LO];
    assign funct = decodeStage.instr[FN_HI:FN_LO];
    assign rs    = decodeStage.instr[RS_HI:RS_LO];
    assign rt    = decodeStage.instr[RT_HI:RT_LO];
    assign rd    = decodeStage.instr[RD_HI:RD_LO];

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        decodeCtrl = '0;
        usesRs     = 1'b0;
        usesRt     = 1'b0;
        isBeq      = 1'b0;
        jump       = 1'b0;
        case (op)
            OP_RTYPE: begin
                if (funct == FN_ADDU || funct == FN_SUBU) begin
                    decodeCtrl.regWrite = 1'b1;
                    decodeCtrl.aluOp    = (funct == FN_SUBU) ? ALU_SUB : ALU_ADD;
                    decodeCtrl.destReg  = rd;
                    usesRs              = 1'b1;
                    usesRt              = 1'b1;
                end
            end
            OP_ORI, OP_LUI: begin
                decodeCtrl.regWrite   = 1'b1;
                decodeCtrl.aluOp      = (op == OP_LUI) ? ALU_LUI : ALU_OR;
                decodeCtrl.aluSrcImm  = 1'b1;
                decodeCtrl.zeroExtend = 1'b1;
                decodeCtrl.destReg    = rt;
                usesRs                = (op == OP_ORI);
            end
            OP_LW: begin
                decodeCtrl.regWrite  = 1'b1;
                decodeCtrl.memRead   = 1'b1;
                decodeCtrl.aluSrcImm = 1'b1;
                decodeCtrl.destReg   = rt;
                usesRs               = 1'b1;
            end
            OP_SW: begin
                decodeCtrl.memWrite  = 1'b1;
                decodeCtrl.aluSrcImm = 1'b1;
                usesRs               = 1'b1;
                usesRt               = 1'b1;
            end
            OP_BEQ: begin
                isBeq  = 1'b1;
                usesRs = 1'b1;
                usesRt = 1'b1;
            end
            OP_J: jump = 1'b1;
            // Anything else is a no-op
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Hazards
    ////////////////////////////////////////////////////////////
    function automatic logic readsReg(input logic [4:0] dest);
        return (dest != 5'd0) && ((usesRs && dest == rs) || (usesRt && dest == rt));
    endfunction

    // Load-use, or beq waiting on a value still in EX or a load in MEM
    assign stall = (executeStage.ctrl.memRead && readsReg(executeStage.ctrl.destReg))
                || (isBeq && executeStage.ctrl.regWrite
                    && readsReg(executeStage.ctrl.destReg))
                || (isBeq && memoryStage.ctrl.memRead
                    && readsReg(memoryStage.ctrl.destReg));

    assign pcEnable   = !stall;
    assign ifIdEnable = !stall;
    assign idExClear  = stall;

    ////////////////////////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////////////////////////
    // MEM result only when it is an ALU value, never load data
    assign memFwdOk = memoryStage.ctrl.regWrite && !memoryStage.ctrl.memRead
                   && memoryStage.ctrl.destReg != 5'd0;
    assign wbFwdOk  = writebackStage.ctrl.regWrite && writebackStage.ctrl.destReg != 5'd0;

    function automatic fwdSel_t selectFwd(input logic [4:0] src);
        if (memFwdOk && memoryStage.ctrl.destReg == src) begin
            return FWD_MEM;
        end else if (wbFwdOk && writebackStage.ctrl.destReg == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    function automatic logic [31:0] forwardValue(input logic [4:0] src,
                                                 input logic [31:0] rfValue);
        fwdSel_t sel;
        sel = selectFwd(src);
        case (sel)
            FWD_MEM: return memoryStage.aluResult;
            FWD_WB:  return writebackStage.writeValue;
            default: return rfValue;
        endcase
    endfunction

    assign operandA    = forwardValue(rs, rfDataA);
    assign operandB    = forwardValue(rt, rfDataB);
    assign branchTaken = isBeq && (operandA == operandB);

    assign fwdA = selectFwd(executeStage.rsNum);
    assign fwdB = selectFwd(executeStage.rtNum);

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
// 32x32 register file, two combinational read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic        writeEnable,
    input  logic [4:0]  writeReg,
    input  logic [4:0]  readRegA,
    input  logic [4:0]  readRegB,
    input  logic [31:0] writeData,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeReg != 5'd0) begin
            regs[writeReg] <= writeData;
        end
    end

    // No write-through here, WB forwarding in control covers it
    assign readDataA = (readRegA == 5'd0) ? '0 : regs[readRegA];
    assign readDataB = (readRegB == 5'd0) ? '0 : regs[readRegB];

endmodule

`default_nettype wire

// ==== logic/fetchUnit.sv ====
// Program counter, next-PC selection and fetch payload
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic            clk,
    input  logic            rst,
    input  logic            pcEnable,
    input  logic            branchTaken,
    input  logic            jump,
    input  mipsPkg::ifId_t  decodeStage,
    input  logic [31:0]     instr,
    output logic [31:0]     instrAddr,
    output mipsPkg::ifId_t  fetchStage
);
    import mipsPkg::*;

    logic [31:0] pc;
    logic [31:0] pcNext;
    logic [31:0] decodePlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [15:0] offset;

    // Targets are relative to the instruction in decode, i.e. the delay slot address
    assign offset       = decodeStage.instr[IMM_HI:IMM_LO];
    assign decodePlus4  = decodeStage.pc + 32'd4;
    assign branchTarget = decodePlus4 + {{14{offset[15]}}, offset, 2'b00};
    assign jumpTarget   = {decodePlus4[31:28], decodeStage.instr[IMM26_HI:IMM_LO], 2'b00};

    always_comb begin
        if (jump) begin
            pcNext = jumpTarget;
        end else if (branchTaken) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (pcEnable) begin
            pc <= pcNext;
        end
    end

    assign instrAddr        = pc;
    assign fetchStage.instr = instr;
    assign fetchStage.pc    = pc;

endmodule

`default_nettype wire

// ==== logic/pipeReg.sv ====
// Pipeline stage register with enable and synchronous clear, generic payload
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // Clear wins over enable so a stall can still insert a bubble
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mipsPkg.sv ====
// Instruction fields, opcodes, ALU encoding, control word and pipeline stage payloads
`default_nettype none

package mipsPkg;

    // Instruction field bit positions
    localparam int OP_HI    = 31;
    localparam int OP_LO    = 26;
    localparam int RS_HI    = 25;
    localparam int RS_LO    = 21;
    localparam int RT_HI    = 20;
    localparam int RT_LO    = 16;
    localparam int RD_HI    = 15;
    localparam int RD_LO    = 11;
    localparam int FN_HI    = 5;
    localparam int FN_LO    = 0;
    localparam int IMM_HI   = 15;
    localparam int IMM_LO   = 0;
    localparam int IMM26_HI = 25;

    // Supported opcodes and function codes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_LUI   = 6'h0F;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;

    localparam logic [31:0] RESET_PC   = 32'h0000_0000;
    localparam int          DMEM_WORDS = 256;

    typedef enum logic [1:0] {
        ALU_ADD, ALU_SUB, ALU_OR, ALU_LUI
    } aluOp_t;

    typedef enum logic [1:0] {
        FWD_NONE, FWD_MEM, FWD_WB
    } fwdSel_t;

    // All zero means bubble
    typedef struct packed {
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        aluOp_t     aluOp;
        logic       aluSrcImm;
        logic       zeroExtend;
        logic [4:0] destReg;
    } ctrlWord_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
    } ifId_t;

    typedef struct packed {
        ctrlWord_t   ctrl;
        logic [31:0] pc;
        logic [4:0]  rsNum;
        logic [4:0]  rtNum;
        logic [31:0] rsValue;
        logic [31:0] rtValue;
        logic [31:0] immWord;
    } idEx_t;

    typedef struct packed {
        ctrlWord_t   ctrl;
        logic [31:0] pc;
        logic [31:0] aluResult;
        logic [31:0] storeData;
    } exMem_t;

    typedef struct packed {
        ctrlWord_t   ctrl;
        logic [31:0] pc;
        logic [31:0] writeValue;
    } memWb_t;

endpackage

`default_nettype wire
